//--- bias_subsystem.f
verilog/bias_pkg.sv
verilog/bias_apb_regs.sv
verilog/bias_regs.sv
verilog/bias_row_sequencer.sv
verilog/bias_subsystem.sv
test/tb_clock_gen.sv
test/bias_subsystem_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := bias_subsystem_tb
FILELIST  := bias_subsystem.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	@grep -qF -- '** PASS **' $(SIM_LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

//--- test/bias_subsystem_tb.sv
`timescale 1ns/1ps

module bias_subsystem_tb;
  import bias_pkg::*;

  // planned counts for the watchdog
  localparam int APB_ACCESSES    = 170;
  localparam int STREAMS         = 5;
  localparam int WATCHDOG_CYCLES = 20 * APB_ACCESSES + 40 * STREAMS + 16 + 200;
  localparam int ROW_WAIT_CYCLES = 400;

  logic        clk;
  logic        arst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  bias_out_t   bias_out;
  logic        out_ready;

  integer      seed = 56;
  logic        ready_random = 1'b0;
  int          sets_errs = 0;
  int          rdata_errs = 0;
  int          err_errs = 0;
  int          other_errs = 0;
  int          rows_seen = 0;
  row_idx_t    exp_row = 6'd1;
  logic        held = 1'b0;
  // shadow of the bias tile, entry k is register k+1
  bias_set_t   shadow [BIAS_REG_NUM];
  bias_word_t  cur_word;

  tb_clock_gen u_clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  bias_subsystem DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .bias_out  (bias_out),
    .out_ready (out_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // load accept rule
  function automatic logic load_accepted(load_mode_t mode, reg_idx_t start, reg_idx_t size);
    int s;
    int n;
    s = int'(start);
    n = int'(size);
    if (s < 1 || n < 1 || s + n - 1 > BIAS_REG_NUM) return 1'b0;
    if (mode == MODE_BYTE) return 1'b1;
    if (mode == MODE_SET) return (s == 1) || (s == BIAS_REG_NUM / 2 + 1);
    return 1'b0;
  endfunction

  // shadow update for an accepted load
  task automatic apply_load(input load_mode_t mode, input int start, input int size,
                            input bias_word_t word);
    int half;
    half = BIAS_REG_NUM / 2;
    for (int e = start; e < start + size; e++) begin
      if (mode == MODE_BYTE) begin
        shadow[e-1] = {8'h00, word[(e-1)*BIAS_WIDTH +: BIAS_WIDTH]};
      end else if (start == 1 && e <= half) begin
        shadow[e-1] = word[(e-1)*BIAS_SET_WIDTH +: BIAS_SET_WIDTH];
      end else if (start == half + 1 && e > half) begin
        shadow[e-1] = word[(e-half-1)*BIAS_SET_WIDTH +: BIAS_SET_WIDTH];
      end else begin
        shadow[e-1] = '0;
      end
    end
  endtask

  // four sets of one row position, array row 1 low
  function automatic lane_sets_t expected_sets(int row);
    lane_sets_t s;
    for (int r = 0; r < SA_ROW_NUM; r++) begin
      s[r*BIAS_SET_WIDTH +: BIAS_SET_WIDTH] = shadow[r*ROW_NUM_IN_SA + row - 1];
    end
    return s;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_sets(input row_idx_t got_row, input lane_sets_t got,
                            input row_idx_t want_row, input lane_sets_t want,
                            input string what);
    if (got_row !== want_row || got !== want) begin
      sets_errs++;
      $display("Fail at %0t ns: %s row %0d sets %h, expected row %0d sets %h",
               $time, what, got_row, got, want_row, want);
    end
  endtask

  task automatic check_rdata(input logic [31:0] got, input logic [31:0] want,
                             input string what);
    if (got !== want) begin
      rdata_errs++;
      $display("Fail at %0t ns: %s read %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_err(input logic got, input logic want, input string what);
    if (got !== want) begin
      err_errs++;
      $display("Fail at %0t ns: %s pslverr %b, expected %b", $time, what, got, want);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // apb and stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // setup, access, then one idle cycle
  task automatic apb_access(input logic write, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    // response is stable mid access phase
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // no wait states in this slave
    if (apb_rsp.pready !== 1'b1) begin
      other_errs++;
      $display("Fail at %0t ns: pready %b in the access phase, expected 1",
               $time, apb_rsp.pready);
    end
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic exp_err, input string what);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    check_err(err, exp_err, what);
  endtask

  task automatic apb_read_check(input logic [11:0] addr, input logic [31:0] want,
                                input string what);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, addr, 32'd0, rd, err);
    check_err(err, 1'b0, what);
    check_rdata(rd, want, what);
  endtask

  task automatic make_random_word(output bias_word_t word);
    for (int b = 0; b < WORD_BEATS; b++) begin
      word[b*32 +: 32] = $random(seed);
    end
  endtask

  task automatic write_word(input bias_word_t word);
    for (int b = 0; b < WORD_BEATS; b++) begin
      apb_write(ADDR_WORD + 12'(4 * b), word[b*32 +: 32], 1'b0, "word beat write");
    end
    cur_word = word;
  endtask

  task automatic set_config(input load_mode_t mode, input int start, input int size);
    apb_write(ADDR_MODE, 32'(mode), 1'b0, "mode write");
    apb_write(ADDR_START, 32'(start), 1'b0, "start write");
    apb_write(ADDR_SIZE, 32'(size), 1'b0, "size write");
  endtask

  // refused loads must give pslverr and leave the shadow alone
  task automatic run_load(input load_mode_t mode, input int start, input int size,
                          input string what);
    logic ok;
    set_config(mode, start, size);
    ok = load_accepted(mode, reg_idx_t'(start), reg_idx_t'(size));
    apb_write(ADDR_CTRL, 32'h1, !ok, what);
    if (ok) begin
      apply_load(mode, start, size, cur_word);
    end
  endtask

  task automatic start_stream(input string what);
    rows_seen = 0;
    exp_row   = 6'd1;
    apb_write(ADDR_CTRL, 32'h2, 1'b0, what);
  endtask

  // wait for all rows, then for busy to clear
  task automatic finish_stream(input string what);
    logic [31:0] rd;
    logic        err;
    int          waited;
    int          polls;
    waited = 0;
    while (rows_seen < ROW_NUM_IN_SA && waited < ROW_WAIT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (rows_seen != ROW_NUM_IN_SA) begin
      other_errs++;
      $display("%s: only %0d of %0d rows arrived in %0d cycles",
               what, rows_seen, ROW_NUM_IN_SA, ROW_WAIT_CYCLES);
    end
    polls = 0;
    rd    = 32'd1;
    while (rd[0] && polls < 8) begin
      apb_access(1'b0, ADDR_STATUS, 32'd0, rd, err);
      polls++;
    end
    if (rd[0]) begin
      other_errs++;
      $display("%s: busy is still set after the last row", what);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////////////////////////

  // random back-pressure only when asked for
  always @(posedge clk) begin
    if (ready_random) begin
      out_ready <= 1'($random(seed));
    end else begin
      out_ready <= 1'b1;
    end
  end

  // rows checked mid cycle, a transfer lands on the next rising edge
  // a stalled row is held against the model every cycle
  always @(negedge clk) begin
    if (arst_n) begin
      if (held && !bias_out.valid) begin
        other_errs++;
        $display("valid dropped while row %0d was stalled", exp_row);
      end
      if (bias_out.valid && int'(exp_row) > ROW_NUM_IN_SA) begin
        if (out_ready) begin
          other_errs++;
          $display("extra row %0d transferred after the last row", bias_out.row_idx);
        end
      end else if (bias_out.valid) begin
        check_sets(bias_out.row_idx, bias_out.sets, exp_row,
                   expected_sets(int'(exp_row)),
                   out_ready ? "streamed row" : "stalled row");
      end
      if (bias_out.valid && out_ready) begin
        exp_row = exp_row + 6'd1;
        rows_seen++;
      end
      held = bias_out.valid && !out_ready;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    bias_word_t w;
    apb_req   = '0;
    out_ready = 1'b1;
    for (int e = 0; e < BIAS_REG_NUM; e++) begin
      shadow[e] = '0;
    end
    wait (arst_n === 1'b1);
    repeat (2) @(posedge clk);

    // full byte load
    make_random_word(w);
    write_word(w);
    run_load(MODE_BYTE, 1, BIAS_REG_NUM, "full byte load");
    start_stream("stream after full load");
    finish_stream("stream after full load");

    // partial byte range, rest of the tile keeps its values
    make_random_word(w);
    write_word(w);
    run_load(MODE_BYTE, 10, 7, "partial byte load");
    start_stream("stream after partial load");
    finish_stream("stream after partial load");

    // both halves in set mode
    make_random_word(w);
    write_word(w);
    run_load(MODE_SET, 1, BIAS_REG_NUM / 2, "set load lower half");
    make_random_word(w);
    write_word(w);
    run_load(MODE_SET, BIAS_REG_NUM / 2 + 1, BIAS_REG_NUM / 2, "set load upper half");
    start_stream("stream after set loads");
    finish_stream("stream after set loads");

    // refused loads
    make_random_word(w);
    write_word(w);
    run_load(MODE_SET, 5, 32, "set load start 5");
    run_load(MODE_BYTE, 0, 8, "byte load start 0");
    run_load(MODE_BYTE, 4, 0, "byte load size 0");
    run_load(MODE_BYTE, 60, 10, "byte load past the end");
    start_stream("stream after refused loads");
    finish_stream("stream after refused loads");

    // random back-pressure, commands refused while busy
    set_config(MODE_BYTE, 1, BIAS_REG_NUM);
    ready_random = 1'b1;
    start_stream("stalled stream");
    apb_read_check(ADDR_STATUS, 32'd1, "status during stream");
    apb_write(ADDR_CTRL, 32'h1, 1'b1, "load while busy");
    apb_write(ADDR_CTRL, 32'h2, 1'b1, "stream while busy");
    finish_stream("stalled stream");
    ready_random = 1'b0;

    // readback of configuration and word beats
    set_config(MODE_SET, BIAS_REG_NUM / 2 + 1, BIAS_REG_NUM / 2);
    apb_read_check(ADDR_MODE, 32'(MODE_SET), "mode readback");
    apb_read_check(ADDR_START, 32'(BIAS_REG_NUM / 2 + 1), "start readback");
    apb_read_check(ADDR_SIZE, 32'(BIAS_REG_NUM / 2), "size readback");
    make_random_word(w);
    write_word(w);
    for (int b = 0; b < WORD_BEATS; b++) begin
      apb_read_check(ADDR_WORD + 12'(4 * b), w[b*32 +: 32], "word beat readback");
    end
    // unmapped offset
    apb_write(12'h020, 32'd0, 1'b1, "unmapped write");

    $display("errors: sets %0d rdata %0d pslverr %0d other %0d",
             sets_errs, rdata_errs, err_errs, other_errs);
    if (sets_errs + rdata_errs + err_errs + other_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  // 10 ns period
  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

//--- verilog/bias_subsystem.sv
`timescale 1ns/1ps

module bias_subsystem (
  input  logic                clk,
  input  logic                arst_n,
  input  bias_pkg::apb_req_t  apb_req,
  output bias_pkg::apb_rsp_t  apb_rsp,
  output bias_pkg::bias_out_t bias_out,
  input  logic                out_ready
);
  import bias_pkg::*;

  logic       bias_set;
  logic       stream_start;
  logic       busy;
  load_cmd_t  load_cmd;
  bias_word_t bias_word;
  row_idx_t   next_row_idx;
  lane_sets_t sets;

  //////////////////////////////////////////////////////////////////////
  // apb registers, tile and sequencer
  //////////////////////////////////////////////////////////////////////

  bias_apb_regs u_apb_regs (
    .clk          (clk),
    .arst_n       (arst_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .busy         (busy),
    .bias_set     (bias_set),
    .load_cmd     (load_cmd),
    .bias_word    (bias_word),
    .stream_start (stream_start)
  );

  bias_regs u_bias_regs (
    .clk          (clk),
    .arst_n       (arst_n),
    .bias_set     (bias_set),
    .load_cmd     (load_cmd),
    .bias_word    (bias_word),
    .next_row_idx (next_row_idx),
    .sets         (sets)
  );

  // sequencer owns the read index of the tile
  bias_row_sequencer u_row_sequencer (
    .clk          (clk),
    .arst_n       (arst_n),
    .stream_start (stream_start),
    .busy         (busy),
    .next_row_idx (next_row_idx),
    .sets         (sets),
    .bias_out     (bias_out),
    .out_ready    (out_ready)
  );

endmodule

//--- verilog/bias_row_sequencer.sv
`timescale 1ns/1ps

module bias_row_sequencer (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 stream_start,
  output logic                 busy,
  output bias_pkg::row_idx_t   next_row_idx,
  input  bias_pkg::lane_sets_t sets,
  output bias_pkg::bias_out_t  bias_out,
  input  logic                 out_ready
);
  import bias_pkg::*;

  seq_state_e state;
  // next row to issue, 0 once all rows are issued
  row_idx_t   issue_idx;
  // row currently held at the output
  row_idx_t   out_row;
  logic       out_valid;
  logic       stall;
  logic       fire;

  assign fire  = out_valid && out_ready;
  assign stall = out_valid && !out_ready;
  assign busy  = (state != SEQ_IDLE);

  // on a stall re-read the presented row so the sets hold
  assign next_row_idx = stall ? out_row : issue_idx;

  //////////////////////////////////////////////////////////////////////
  // row stepping
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= SEQ_IDLE;
      issue_idx <= '0;
      out_row   <= '0;
      out_valid <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (stream_start) begin
            issue_idx <= 6'd1;
            state     <= SEQ_RUN;
          end
        end
        // issue on a transfer or into an empty slot
        SEQ_RUN: begin
          if (!stall) begin
            out_valid <= 1'b1;
            out_row   <= issue_idx;
            if (issue_idx == row_idx_t'(ROW_NUM_IN_SA)) begin
              issue_idx <= '0;
              state     <= SEQ_DRAIN;
            end else begin
              issue_idx <= issue_idx + 6'd1;
            end
          end
        end
        // last row still waiting at the output
        SEQ_DRAIN: begin
          if (fire) begin
            out_valid <= 1'b0;
            state     <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // sets arrive with the same one-cycle delay as valid and row
  assign bias_out = '{valid: out_valid, row_idx: out_row, sets: sets};

  // read index must stay inside one array
  a_idx_range: assert property (
    @(posedge clk) disable iff (!arst_n) next_row_idx <= row_idx_t'(ROW_NUM_IN_SA)
  );

endmodule

//--- verilog/bias_regs.sv
`timescale 1ns/1ps

module bias_regs (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 bias_set,
  input  bias_pkg::load_cmd_t  load_cmd,
  input  bias_pkg::bias_word_t bias_word,
  input  bias_pkg::row_idx_t   next_row_idx,
  output bias_pkg::lane_sets_t sets
);
  import bias_pkg::*;

  localparam int HALF_REGS = BIAS_REG_NUM / 2;

  bias_set_t               tile    [BIAS_REG_NUM];
  bias_set_t               wr_data [BIAS_REG_NUM];
  logic [BIAS_REG_NUM-1:0] wr_mask;
  logic [8:0]              reg_end;
  row_idx_t                rd_ofs;

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  // inclusive end of the load range, one based
  assign reg_end = {1'b0, load_cmd.reg_start} + {1'b0, load_cmd.reg_size} - 9'd1;

  // entry k is register k+1
  always_comb begin
    for (int k = 0; k < BIAS_REG_NUM; k++) begin
      wr_mask[k] = (9'(k + 1) >= {1'b0, load_cmd.reg_start}) &&
                   (9'(k + 1) <= reg_end);
    end
  end

  // write data per entry by mode
  always_comb begin
    bias_t byte_val;
    byte_val = '0;
    for (int k = 0; k < BIAS_REG_NUM; k++) begin
      byte_val = bias_word[k*BIAS_WIDTH +: BIAS_WIDTH];
      wr_data[k] = '0;
      case (load_cmd.mode)
        // one zero-extended byte per register
        MODE_BYTE: begin
          wr_data[k] = {{(BIAS_SET_WIDTH - BIAS_WIDTH){1'b0}}, byte_val};
        end
        // the word's sets go to the half picked by the start register
        MODE_SET: begin
          if (k < HALF_REGS) begin
            if (load_cmd.reg_start == 8'd1) begin
              wr_data[k] = bias_word[k*BIAS_SET_WIDTH +: BIAS_SET_WIDTH];
            end
          end else begin
            if (load_cmd.reg_start == 8'(HALF_REGS + 1)) begin
              wr_data[k] = bias_word[(k - HALF_REGS)*BIAS_SET_WIDTH +: BIAS_SET_WIDTH];
            end
          end
        end
        default: wr_data[k] = '0;
      endcase
    end
  end

  // only masked entries move
  always_ff @(posedge clk) begin
    for (int k = 0; k < BIAS_REG_NUM; k++) begin
      if (bias_set && wr_mask[k]) begin
        tile[k] <= wr_data[k];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  // zero based position inside one array
  assign rd_ofs = next_row_idx - 6'd1;

  // one entry per array row, same position in each
  // index 0 keeps the last value
  always_ff @(posedge clk) begin
    if (next_row_idx != '0) begin
      for (int r = 0; r < SA_ROW_NUM; r++) begin
        sets[r*BIAS_SET_WIDTH +: BIAS_SET_WIDTH] <= tile[r*ROW_NUM_IN_SA + int'(rd_ofs)];
      end
    end
  end

  // range check upstream keeps start one based
  a_start_nonzero: assert property (
    @(posedge clk) disable iff (!arst_n) bias_set |-> (load_cmd.reg_start != '0)
  );

endmodule

//--- verilog/bias_apb_regs.sv
`timescale 1ns/1ps

module bias_apb_regs (
  input  logic                 clk,
  input  logic                 arst_n,
  input  bias_pkg::apb_req_t   apb_req,
  output bias_pkg::apb_rsp_t   apb_rsp,
  input  logic                 busy,
  output logic                 bias_set,
  output bias_pkg::load_cmd_t  load_cmd,
  output bias_pkg::bias_word_t bias_word,
  output logic                 stream_start
);
  import bias_pkg::*;

  localparam int BEAT_BITS = $clog2(WORD_BEATS);

  logic                 access;
  logic                 wr_access;
  logic                 rd_access;
  logic                 hit_ctrl;
  logic                 hit_mode;
  logic                 hit_start;
  logic                 hit_size;
  logic                 hit_status;
  logic                 hit_word;
  logic                 mapped;
  logic [BEAT_BITS-1:0] beat_idx;
  load_mode_t           cfg_mode;
  reg_idx_t             cfg_start;
  reg_idx_t             cfg_size;
  logic [8:0]           range_end;
  logic                 range_ok;
  logic                 load_req;
  logic                 stream_req;
  logic                 load_ok;
  logic                 cmd_err;
  logic [31:0]          rdata;
  bias_word_t           word_buf;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  // every access finishes in its access phase
  assign access    = apb_req.psel && apb_req.penable;
  assign wr_access = access && apb_req.pwrite;
  assign rd_access = access && !apb_req.pwrite;

  assign hit_ctrl   = (apb_req.paddr == ADDR_CTRL);
  assign hit_mode   = (apb_req.paddr == ADDR_MODE);
  assign hit_start  = (apb_req.paddr == ADDR_START);
  assign hit_size   = (apb_req.paddr == ADDR_SIZE);
  assign hit_status = (apb_req.paddr == ADDR_STATUS);
  // word window, word aligned only
  assign hit_word   = (apb_req.paddr >= ADDR_WORD) &&
                      (apb_req.paddr < ADDR_WORD + 12'(4 * WORD_BEATS)) &&
                      (apb_req.paddr[1:0] == 2'b00);
  assign mapped     = hit_ctrl || hit_mode || hit_start || hit_size ||
                      hit_status || hit_word;
  // window base is aligned, so the low address bits pick the beat
  assign beat_idx   = apb_req.paddr[2 +: BEAT_BITS];

  //////////////////////////////////////////////////////////////////////
  // load range check and commands
  //////////////////////////////////////////////////////////////////////

  // last register touched, 9 bits so an overflow stays visible
  assign range_end = {1'b0, cfg_start} + {1'b0, cfg_size} - 9'd1;

  always_comb begin
    range_ok = (cfg_start != '0) && (cfg_size != '0) &&
               (range_end <= 9'(BIAS_REG_NUM));
    case (cfg_mode)
      MODE_BYTE: ;
      // set mode fills exactly one half of the tile
      MODE_SET: begin
        if ((cfg_start != 8'd1) && (cfg_start != 8'(BIAS_REG_NUM / 2 + 1))) begin
          range_ok = 1'b0;
        end
      end
      default: range_ok = 1'b0;
    endcase
  end

  // load bit wins when both bits are written together
  assign load_req   = wr_access && hit_ctrl && apb_req.pwdata[CTRL_LOAD_BIT];
  assign stream_req = wr_access && hit_ctrl && apb_req.pwdata[CTRL_STREAM_BIT] &&
                      !apb_req.pwdata[CTRL_LOAD_BIT];
  assign load_ok    = load_req && range_ok && !busy;
  assign cmd_err    = (load_req && (!range_ok || busy)) || (stream_req && busy);

  // stream starts in the access cycle itself
  assign stream_start = stream_req && !busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg_mode  <= MODE_BYTE;
      cfg_start <= 8'd1;
      cfg_size  <= 8'(BIAS_REG_NUM);
      bias_set  <= 1'b0;
    end else begin
      // tile write one cycle after the accepted access
      bias_set <= load_ok;
      if (wr_access && hit_mode) begin
        cfg_mode <= apb_req.pwdata[$bits(load_mode_t)-1:0];
      end
      if (wr_access && hit_start) begin
        cfg_start <= apb_req.pwdata[$bits(reg_idx_t)-1:0];
      end
      if (wr_access && hit_size) begin
        cfg_size <= apb_req.pwdata[$bits(reg_idx_t)-1:0];
      end
    end
  end

  // staging buffer for the bias word
  always_ff @(posedge clk) begin
    if (wr_access && hit_word) begin
      word_buf[beat_idx*32 +: 32] <= apb_req.pwdata;
    end
  end

  // readback, ctrl reads as zero
  always_comb begin
    rdata = '0;
    if (hit_mode) begin
      rdata = 32'(cfg_mode);
    end else if (hit_start) begin
      rdata = 32'(cfg_start);
    end else if (hit_size) begin
      rdata = 32'(cfg_size);
    end else if (hit_status) begin
      rdata = {31'd0, busy};
    end else if (hit_word) begin
      rdata = word_buf[beat_idx*32 +: 32];
    end
  end

  assign apb_rsp   = '{prdata:  rd_access ? rdata : 32'd0,
                       pready:  1'b1,
                       pslverr: access && (!mapped || cmd_err)};
  assign load_cmd  = '{mode: cfg_mode, reg_start: cfg_start, reg_size: cfg_size};
  assign bias_word = word_buf;

  // relies on the apb setup phase between two accesses
  a_no_load_and_stream: assert property (
    @(posedge clk) disable iff (!arst_n) !(bias_set && stream_start)
  );

endmodule

//--- verilog/bias_pkg.sv
package bias_pkg;

  //////////////////////////////////////////////////////////////////////
  // array geometry and sizes
  //////////////////////////////////////////////////////////////////////

  // systolic-array rows in the core
  localparam int SA_ROW_NUM      = 4;
  // row positions in one array
  localparam int ROW_NUM_IN_SA   = 16;
  // entries in the bias tile, one per row position of every array row
  localparam int BIAS_REG_NUM    = SA_ROW_NUM * ROW_NUM_IN_SA;
  localparam int BIAS_WIDTH      = 8;
  localparam int BIAS_SET_WIDTH  = 16;
  localparam int BIAS_WORD_WIDTH = 512;
  // 32-bit apb beats per bias word
  localparam int WORD_BEATS      = BIAS_WORD_WIDTH / 32;

  typedef logic [BIAS_WIDTH-1:0]                bias_t;
  typedef logic [BIAS_SET_WIDTH-1:0]            bias_set_t;
  typedef logic [BIAS_WORD_WIDTH-1:0]           bias_word_t;
  // array row 1 sits in the low bits
  typedef logic [SA_ROW_NUM*BIAS_SET_WIDTH-1:0] lane_sets_t;
  // one-based tile index
  typedef logic [7:0]                           reg_idx_t;
  // one-based row index, 0 means none
  typedef logic [5:0]                           row_idx_t;
  typedef logic [3:0]                           load_mode_t;

  localparam load_mode_t MODE_BYTE = 4'd0;
  localparam load_mode_t MODE_SET  = 4'd1;

  //////////////////////////////////////////////////////////////////////
  // bus and stream structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    load_mode_t mode;
    reg_idx_t   reg_start;
    reg_idx_t   reg_size;
  } load_cmd_t;

  typedef struct packed {
    logic       valid;
    row_idx_t   row_idx;
    lane_sets_t sets;
  } bias_out_t;

  // register map, byte offsets
  localparam logic [11:0] ADDR_CTRL   = 12'h000;
  localparam logic [11:0] ADDR_MODE   = 12'h004;
  localparam logic [11:0] ADDR_START  = 12'h008;
  localparam logic [11:0] ADDR_SIZE   = 12'h00C;
  localparam logic [11:0] ADDR_STATUS = 12'h010;
  // first of WORD_BEATS consecutive beats
  localparam logic [11:0] ADDR_WORD   = 12'h040;

  // ctrl bits
  localparam int CTRL_LOAD_BIT   = 0;
  localparam int CTRL_STREAM_BIT = 1;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_DRAIN
  } seq_state_e;

endpackage
